//--- mips_mmu_pkg.sv
// shared MMU constants and enums; 32-bit addresses, 4 KB pages only, no ASID
package mips_mmu_pkg;

    // TLB geometry
    localparam int tlb_entries = 8;
    localparam int tlb_index_w = 3;

    // page split of a 32-bit virtual address
    localparam int vpn_w      = 20;
    localparam int pfn_w      = 20;
    localparam int page_off_w = 12;

    // segment select lives in vaddr[31:29]
    localparam int seg_lsb = 29;

    localparam logic [2:0] seg_kseg0 = 3'b100; // unmapped, K0 cacheability
    localparam logic [2:0] seg_kseg1 = 3'b101; // unmapped, uncached
    localparam logic [2:0] seg_kseg2 = 3'b110; // mapped
    localparam logic [2:0] seg_kseg3 = 3'b111; // mapped

    // Status and Config field positions
    localparam int erl_bit = 2;
    localparam int k0_lsb  = 0;
    localparam int ku_lsb  = 25;
    localparam int k23_lsb = 28;

    // cacheability code, anything else is uncached
    localparam logic [2:0] cca_cached = 3'd3;

    // EntryLo layout
    localparam int lo_v_bit   = 1;
    localparam int lo_d_bit   = 2;
    localparam int lo_c_bit   = 3;
    localparam int lo_pfn_lsb = 12;

    // register picked by a CP0 move
    typedef enum logic [2:0] {
        cp0_index,
        cp0_entryhi,
        cp0_entrylo,
        cp0_status,
        cp0_config
    } cp0_reg_e;

    // outcome of a TLB lookup
    typedef enum logic [1:0] {
        exc_none,
        exc_refill,
        exc_invalid,
        exc_modified
    } tlb_exc_e;

endpackage

//--- cp0_mmu_regs.sv
// keeps only ERL, K0/KU/K23 and the TLB write staging registers; writes land at the cp0_wen edge
`timescale 1ns/1ps

module cp0_mmu_regs (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   cp0_wen,
    input  mips_mmu_pkg::cp0_reg_e                 cp0_sel,
    input  logic [31:0]                            cp0_wdata,
    output logic                                   status_erl,
    output logic [2:0]                             cfg_k0,
    output logic [2:0]                             cfg_ku,
    output logic [2:0]                             cfg_k23,
    output logic [mips_mmu_pkg::tlb_index_w-1:0]   tlb_index,
    output logic [31:0]                            entry_hi,
    output logic [31:0]                            entry_lo
);

    // Status and Config: ERL comes up set, caching off
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            status_erl <= 1'b1;
            cfg_k0     <= '0;
            cfg_ku     <= '0;
            cfg_k23    <= '0;
        end else if (cp0_wen) begin
            case (cp0_sel)
                mips_mmu_pkg::cp0_status: begin
                    status_erl <= cp0_wdata[mips_mmu_pkg::erl_bit];
                end
                mips_mmu_pkg::cp0_config: begin
                    cfg_k0  <= cp0_wdata[mips_mmu_pkg::k0_lsb +: 3];
                    cfg_ku  <= cp0_wdata[mips_mmu_pkg::ku_lsb +: 3];
                    cfg_k23 <= cp0_wdata[mips_mmu_pkg::k23_lsb +: 3];
                end
                default: ; // other selects belong to the staging block
            endcase
        end
    end

    // Index, EntryHi, EntryLo feed the next tlb_write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            tlb_index <= '0;
            entry_hi  <= '0;
            entry_lo  <= '0;
        end else if (cp0_wen) begin
            case (cp0_sel)
                mips_mmu_pkg::cp0_index: begin
                    tlb_index <= cp0_wdata[mips_mmu_pkg::tlb_index_w-1:0];
                end
                mips_mmu_pkg::cp0_entryhi: begin
                    entry_hi <= cp0_wdata;
                end
                mips_mmu_pkg::cp0_entrylo: begin
                    entry_lo <= cp0_wdata;
                end
                default: ;
            endcase
        end
    end

endmodule

//--- tlb.sv
// 8-entry fully associative TLB, 4 KB pages, no ASID; vaddr must be held across a micro miss
`timescale 1ns/1ps

module tlb (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   tlb_write,
    input  logic [mips_mmu_pkg::tlb_index_w-1:0]   tlb_index,
    input  logic [31:0]                            entry_hi,
    input  logic [31:0]                            entry_lo,
    input  logic                                   tlb_en,
    input  logic [31:0]                            tlb_vaddr,
    input  logic                                   tlb_refs,
    output logic                                   tlb_rdy,
    output logic [31:0]                            tlb_paddr,
    output logic                                   tlb_cat,
    output mips_mmu_pkg::tlb_exc_e                 tlb_exc
);

    logic [mips_mmu_pkg::vpn_w-1:0]       ent_vpn [mips_mmu_pkg::tlb_entries];
    logic [mips_mmu_pkg::pfn_w-1:0]       ent_pfn [mips_mmu_pkg::tlb_entries];
    logic [mips_mmu_pkg::tlb_entries-1:0] ent_v;
    logic [mips_mmu_pkg::tlb_entries-1:0] ent_d;
    logic [mips_mmu_pkg::tlb_entries-1:0] ent_c;

    logic [mips_mmu_pkg::vpn_w-1:0]       req_vpn;
    logic                                 hit;
    logic [mips_mmu_pkg::tlb_index_w-1:0] hit_idx;
    mips_mmu_pkg::tlb_exc_e               walk_exc;
    logic                                 walk_ld;

    logic                                 utlb_v;
    logic [mips_mmu_pkg::vpn_w-1:0]       utlb_vpn;
    logic [mips_mmu_pkg::pfn_w-1:0]       utlb_pfn;
    logic                                 utlb_d;
    logic                                 utlb_c;
    logic                                 utlb_ok;

    logic                                 exc_v;
    logic [mips_mmu_pkg::vpn_w-1:0]       exc_vpn;
    logic                                 exc_refs;
    mips_mmu_pkg::tlb_exc_e               exc_code;

    assign req_vpn = tlb_vaddr[mips_mmu_pkg::page_off_w +: mips_mmu_pkg::vpn_w];

    // parallel compare, walk downward so the lowest index wins
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = mips_mmu_pkg::tlb_entries - 1; i >= 0; i--) begin
            if (ent_vpn[i] == req_vpn) begin
                hit     = 1'b1;
                hit_idx = mips_mmu_pkg::tlb_index_w'(i);
            end
        end
    end

    always_comb begin
        if (!hit)
            walk_exc = mips_mmu_pkg::exc_refill;
        else if (!ent_v[hit_idx])
            walk_exc = mips_mmu_pkg::exc_invalid;
        else if (tlb_refs && !ent_d[hit_idx])
            walk_exc = mips_mmu_pkg::exc_modified;
        else
            walk_exc = mips_mmu_pkg::exc_none;
    end

    // clean page on a store falls back to the full compare
    assign utlb_ok = tlb_en && utlb_v && (utlb_vpn == req_vpn) && !(tlb_refs && !utlb_d);
    assign walk_ld = tlb_en && !utlb_ok && !tlb_write;

    always_ff @(posedge clk) begin
        if (!rst_n)
            ent_v <= '0;
        else if (tlb_write)
            ent_v[tlb_index] <= entry_lo[mips_mmu_pkg::lo_v_bit];
    end

    always_ff @(posedge clk) begin
        if (tlb_write) begin
            ent_vpn[tlb_index] <= entry_hi[mips_mmu_pkg::page_off_w +: mips_mmu_pkg::vpn_w];
            ent_pfn[tlb_index] <= entry_lo[mips_mmu_pkg::lo_pfn_lsb +: mips_mmu_pkg::pfn_w];
            ent_d[tlb_index]   <= entry_lo[mips_mmu_pkg::lo_d_bit];
            ent_c[tlb_index]   <= entry_lo[mips_mmu_pkg::lo_c_bit];
        end
    end

    // micro buffer, flushed by any entry write
    always_ff @(posedge clk) begin
        if (!rst_n || tlb_write)
            utlb_v <= 1'b0;
        else if (walk_ld && walk_exc == mips_mmu_pkg::exc_none)
            utlb_v <= 1'b1;
    end

    always_ff @(posedge clk) begin
        if (walk_ld && walk_exc == mips_mmu_pkg::exc_none) begin
            utlb_vpn <= req_vpn;
            utlb_pfn <= ent_pfn[hit_idx];
            utlb_d   <= ent_d[hit_idx];
            utlb_c   <= ent_c[hit_idx];
        end
    end

    // failed walk shows for the request that caused it only
    always_ff @(posedge clk) begin
        if (!rst_n)
            exc_v <= 1'b0;
        else
            exc_v <= walk_ld && (walk_exc != mips_mmu_pkg::exc_none);
    end

    always_ff @(posedge clk) begin
        exc_vpn  <= req_vpn;
        exc_refs <= tlb_refs;
        exc_code <= walk_exc;
    end

    assign tlb_rdy   = utlb_ok;
    assign tlb_paddr = {utlb_pfn, tlb_vaddr[mips_mmu_pkg::page_off_w-1:0]};
    assign tlb_cat   = utlb_c;
    assign tlb_exc   = (exc_v && tlb_en && exc_vpn == req_vpn && exc_refs == tlb_refs) ?
                       exc_code : mips_mmu_pkg::exc_none;

endmodule

//--- mmu.sv
// combinational segment decode; with ERL set, mapped segments take the kseg1 address map, uncached
`timescale 1ns/1ps

module mmu (
    input  logic                   en,
    input  logic [3:0]             wen,
    input  logic [31:0]            vaddr,
    input  logic [31:0]            wdata,
    output logic [31:0]            rdata,

    output logic                   bus_en,
    output logic [3:0]             bus_wen,
    output logic [31:0]            bus_paddr,
    output logic [31:0]            bus_wdata,
    input  logic [31:0]            bus_rdata,
    input  logic                   bus_streq,
    output logic                   bus_cached,

    output logic                   tlb_en,
    output logic [31:0]            tlb_vaddr,
    output logic                   tlb_refs,
    input  logic                   tlb_rdy,
    input  logic [31:0]            tlb_paddr,
    input  logic                   tlb_cat,
    input  mips_mmu_pkg::tlb_exc_e tlb_exc,

    input  logic                   exc_flag,
    input  logic                   status_erl,
    input  logic [2:0]             cfg_k0,
    input  logic [2:0]             cfg_ku,
    input  logic [2:0]             cfg_k23,
    output logic                   stallreq
);

    logic [2:0]  seg;
    logic [31:0] unmapped_addr;
    logic        tlb_wait;

    assign seg           = vaddr[31:mips_mmu_pkg::seg_lsb];
    assign unmapped_addr = {3'b000, vaddr[mips_mmu_pkg::seg_lsb-1:0]};

    assign bus_wen   = en ? wen : 4'b0000; // byte enables only with a live access
    assign bus_wdata = wdata;
    assign rdata     = en ? bus_rdata : 32'd0;

    // lookup still open: neither translated nor faulted
    assign tlb_wait = tlb_en && !tlb_rdy && (tlb_exc == mips_mmu_pkg::exc_none);
    assign stallreq = bus_streq || tlb_wait;

    always_comb begin
        tlb_en     = 1'b0;
        tlb_vaddr  = 32'd0;
        tlb_refs   = 1'b0;
        bus_en     = 1'b0;
        bus_paddr  = 32'd0;
        bus_cached = 1'b0;

        if (en && !exc_flag) begin
            case (seg)
                mips_mmu_pkg::seg_kseg0: begin
                    bus_en     = 1'b1;
                    bus_paddr  = unmapped_addr;
                    bus_cached = (cfg_k0 == mips_mmu_pkg::cca_cached);
                end
                mips_mmu_pkg::seg_kseg1: begin
                    bus_en     = 1'b1;
                    bus_paddr  = unmapped_addr; // never cached
                end
                default: begin // kuseg, kseg2, kseg3
                    if (status_erl) begin
                        bus_en     = 1'b1;
                        bus_paddr  = unmapped_addr; // same map as kseg1, never cached
                    end else begin
                        tlb_en     = 1'b1;
                        tlb_vaddr  = vaddr;
                        tlb_refs   = (wen != 4'b0000); // any byte write is a store
                        bus_en     = tlb_rdy;
                        bus_paddr  = tlb_paddr;
                        bus_cached = tlb_cat;
                    end
                end
            endcase
        end
    end

endmodule

//--- mmu_subsystem.sv
// translation top level; bus is reduced to its stall input and read data passes straight through
`timescale 1ns/1ps

module mmu_subsystem (
    input  logic                   clk,
    input  logic                   rst_n,

    input  logic                   en,
    input  logic [3:0]             wen,
    input  logic [31:0]            vaddr,
    input  logic [31:0]            wdata,
    input  logic                   exc_flag,
    output logic [31:0]            rdata,
    output logic                   stallreq,
    output mips_mmu_pkg::tlb_exc_e tlb_exc,

    output logic                   bus_en,
    output logic [3:0]             bus_wen,
    output logic [31:0]            bus_paddr,
    output logic [31:0]            bus_wdata,
    input  logic [31:0]            bus_rdata,
    input  logic                   bus_streq,
    output logic                   bus_cached,

    input  logic                   cp0_wen,
    input  mips_mmu_pkg::cp0_reg_e cp0_sel,
    input  logic [31:0]            cp0_wdata,
    input  logic                   tlb_write
);

    logic                                 status_erl;
    logic [2:0]                           cfg_k0;
    logic [2:0]                           cfg_ku;
    logic [2:0]                           cfg_k23;
    logic [mips_mmu_pkg::tlb_index_w-1:0] tlb_index;
    logic [31:0]                          entry_hi;
    logic [31:0]                          entry_lo;

    logic                                 tlb_en;
    logic [31:0]                          tlb_vaddr;
    logic                                 tlb_refs;
    logic                                 tlb_rdy;
    logic [31:0]                          tlb_paddr;
    logic                                 tlb_cat;

    cp0_mmu_regs cp0_mmu_regs_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cp0_wen    (cp0_wen),
        .cp0_sel    (cp0_sel),
        .cp0_wdata  (cp0_wdata),
        .status_erl (status_erl),
        .cfg_k0     (cfg_k0),
        .cfg_ku     (cfg_ku),
        .cfg_k23    (cfg_k23),
        .tlb_index  (tlb_index),
        .entry_hi   (entry_hi),
        .entry_lo   (entry_lo)
    );

    tlb tlb_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .tlb_write (tlb_write),
        .tlb_index (tlb_index),
        .entry_hi  (entry_hi),
        .entry_lo  (entry_lo),
        .tlb_en    (tlb_en),
        .tlb_vaddr (tlb_vaddr),
        .tlb_refs  (tlb_refs),
        .tlb_rdy   (tlb_rdy),
        .tlb_paddr (tlb_paddr),
        .tlb_cat   (tlb_cat),
        .tlb_exc   (tlb_exc)
    );

    mmu mmu_inst (
        .en         (en),
        .wen        (wen),
        .vaddr      (vaddr),
        .wdata      (wdata),
        .rdata      (rdata),
        .bus_en     (bus_en),
        .bus_wen    (bus_wen),
        .bus_paddr  (bus_paddr),
        .bus_wdata  (bus_wdata),
        .bus_rdata  (bus_rdata),
        .bus_streq  (bus_streq),
        .bus_cached (bus_cached),
        .tlb_en     (tlb_en),
        .tlb_vaddr  (tlb_vaddr),
        .tlb_refs   (tlb_refs),
        .tlb_rdy    (tlb_rdy),
        .tlb_paddr  (tlb_paddr),
        .tlb_cat    (tlb_cat),
        .tlb_exc    (tlb_exc),
        .exc_flag   (exc_flag),
        .status_erl (status_erl),
        .cfg_k0     (cfg_k0),
        .cfg_ku     (cfg_ku),
        .cfg_k23    (cfg_k23),
        .stallreq   (stallreq)
    );

endmodule

//--- tb_clock_gen.sv
// testbench clock, 100 ns period; rst_n stays low for the first ten rising edges
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1; // released on the edge, like any other input
    end

endmodule

//--- mmu_subsystem_tb.sv
// testbench for mmu_subsystem; mapped pages get distinct VPNs, so at most one entry matches
`timescale 1ns/1ps

module mmu_subsystem_tb;

    logic                   clk;
    logic                   rst_n;
    logic                   en;
    logic [3:0]             wen;
    logic [31:0]            vaddr;
    logic [31:0]            wdata;
    logic                   exc_flag;
    logic [31:0]            rdata;
    logic                   stallreq;
    mips_mmu_pkg::tlb_exc_e tlb_exc;
    logic                   bus_en;
    logic [3:0]             bus_wen;
    logic [31:0]            bus_paddr;
    logic [31:0]            bus_wdata;
    logic [31:0]            bus_rdata;
    logic                   bus_streq;
    logic                   bus_cached;
    logic                   cp0_wen;
    mips_mmu_pkg::cp0_reg_e cp0_sel;
    logic [31:0]            cp0_wdata;
    logic                   tlb_write;

    // model copy of CP0 fields and TLB entries
    logic                   m_erl;
    logic [2:0]             m_k0;
    logic [19:0]            m_vpn [8];
    logic [19:0]            m_pfn [8];
    logic [7:0]             m_v;
    logic [7:0]             m_d;
    logic [7:0]             m_c;

    // expected values for the compare process
    logic [31:0]            exp_paddr;
    logic [31:0]            exp_rdata;
    logic [31:0]            exp_wdata;
    logic [3:0]             exp_bwen;
    logic                   exp_cached;
    logic                   exp_ben;
    logic                   exp_tlb_en;
    mips_mmu_pkg::tlb_exc_e exp_exc;
    event                   check_ev;
    int                     value_errors;
    int                     timeout_errors;
    int                     last_wait;

    tb_clock_gen tb_clock_gen_inst (
        .clk   (clk),
        .rst_n (rst_n)
    );

    mmu_subsystem mmu_subsystem_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .en         (en),
        .wen        (wen),
        .vaddr      (vaddr),
        .wdata      (wdata),
        .exc_flag   (exc_flag),
        .rdata      (rdata),
        .stallreq   (stallreq),
        .tlb_exc    (tlb_exc),
        .bus_en     (bus_en),
        .bus_wen    (bus_wen),
        .bus_paddr  (bus_paddr),
        .bus_wdata  (bus_wdata),
        .bus_rdata  (bus_rdata),
        .bus_streq  (bus_streq),
        .bus_cached (bus_cached),
        .cp0_wen    (cp0_wen),
        .cp0_sel    (cp0_sel),
        .cp0_wdata  (cp0_wdata),
        .tlb_write  (tlb_write)
    );

    function automatic int find_entry(input logic [19:0] vpn);
        for (int i = 0; i < 8; i++) begin
            if (m_vpn[i] === vpn)
                return i; // lowest index wins
        end
        return -1;
    endfunction

    // kuseg (000..011), kseg2 or kseg3
    function automatic logic [2:0] pick_mapped_seg();
        logic [2:0] s;
        s = 3'($urandom_range(5, 0));
        return (s > 3'd3) ? s + 3'd2 : s;
    endfunction

    function automatic void ref_translate(
        input  logic                   a_en,
        input  logic [3:0]             a_wen,
        input  logic [31:0]            a_vaddr,
        input  logic                   a_exc_flag,
        input  logic [31:0]            a_bus_rdata,
        output logic [31:0]            o_paddr,
        output logic                   o_cached,
        output logic                   o_ben,
        output logic                   o_tlb_en,
        output logic [3:0]             o_bwen,
        output logic [31:0]            o_rdata,
        output mips_mmu_pkg::tlb_exc_e o_exc
    );
        logic [2:0] seg;
        int         idx;
        seg      = a_vaddr[31:29];
        o_paddr  = {3'b000, a_vaddr[28:0]}; // unmapped view
        o_cached = 1'b0;
        o_ben    = 1'b0;
        o_tlb_en = 1'b0;
        o_exc    = mips_mmu_pkg::exc_none;
        o_bwen   = a_en ? a_wen : 4'd0;
        o_rdata  = a_en ? a_bus_rdata : 32'd0;
        if (a_en && !a_exc_flag) begin
            if (seg == 3'b100) begin
                o_ben    = 1'b1;
                o_cached = (m_k0 == 3'd3);
            end else if (seg == 3'b101) begin
                o_ben = 1'b1; // kseg1 never cached
            end else if (m_erl) begin
                o_ben = 1'b1; // treated like kseg1
            end else begin
                o_tlb_en = 1'b1;
                idx      = find_entry(a_vaddr[31:12]);
                if (idx < 0)
                    o_exc = mips_mmu_pkg::exc_refill;
                else if (!m_v[idx])
                    o_exc = mips_mmu_pkg::exc_invalid;
                else if ((a_wen != 4'd0) && !m_d[idx])
                    o_exc = mips_mmu_pkg::exc_modified;
                else begin
                    o_ben    = 1'b1;
                    o_paddr  = {m_pfn[idx], a_vaddr[11:0]};
                    o_cached = m_c[idx];
                end
            end
        end
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] got_v);
        $display("** Error at %0t: %s expected %h, got %h", $time, name, exp_v, got_v);
        value_errors++;
    endtask

    task automatic cp0_write(input mips_mmu_pkg::cp0_reg_e sel, input logic [31:0] data);
        @(posedge clk);
        cp0_wen   <= 1'b1;
        cp0_sel   <= sel;
        cp0_wdata <= data;
        @(posedge clk);
        cp0_wen   <= 1'b0;
    endtask

    task automatic write_config(input logic [2:0] k0, input logic [2:0] ku,
                                input logic [2:0] k23);
        cp0_write(mips_mmu_pkg::cp0_config, {1'b0, k23, ku, 22'd0, k0});
        m_k0 = k0;
    endtask

    task automatic write_entry(input int i, input logic [19:0] vpn, input logic [19:0] pfn,
                               input logic v, input logic d, input logic c);
        cp0_write(mips_mmu_pkg::cp0_index, 32'(i));
        cp0_write(mips_mmu_pkg::cp0_entryhi, {vpn, 12'd0});
        cp0_write(mips_mmu_pkg::cp0_entrylo, {pfn, 8'd0, c, d, v, 1'b0});
        @(posedge clk);
        tlb_write <= 1'b1;
        @(posedge clk);
        tlb_write <= 1'b0;
        m_vpn[i] = vpn;
        m_pfn[i] = pfn;
        m_v[i]   = v;
        m_d[i]   = d;
        m_c[i]   = c;
    endtask

    // drive one access, wait for the stall to drop, hand expectations to the checker
    task automatic run_access(input logic a_en, input logic [3:0] a_wen,
                              input logic [31:0] a_vaddr, input logic a_exc_flag);
        logic [31:0] rd;
        logic [31:0] wd;
        rd = $urandom;
        wd = $urandom;
        @(posedge clk);
        en        <= a_en;
        wen       <= a_wen;
        vaddr     <= a_vaddr;
        exc_flag  <= a_exc_flag;
        wdata     <= wd;
        bus_rdata <= rd;
        last_wait = 0;
        @(negedge clk);
        while (stallreq && last_wait < 8) begin
            @(negedge clk);
            last_wait++;
        end
        if (stallreq) begin
            $display("stall never cleared for the access to %h at %0t", a_vaddr, $time);
            timeout_errors++;
        end else begin
            ref_translate(a_en, a_wen, a_vaddr, a_exc_flag, rd, exp_paddr, exp_cached,
                          exp_ben, exp_tlb_en, exp_bwen, exp_rdata, exp_exc);
            exp_wdata = wd; // write data passes straight through
            -> check_ev;
        end
    endtask

    always @(check_ev) begin
        assert (bus_en === exp_ben)
            else report_mismatch("bus_en", 32'(exp_ben), 32'(bus_en));
        assert (mmu_subsystem_inst.tlb_en === exp_tlb_en)
            else report_mismatch("tlb_en", 32'(exp_tlb_en), 32'(mmu_subsystem_inst.tlb_en));
        assert (tlb_exc === exp_exc)
            else report_mismatch("tlb_exc", 32'(exp_exc), 32'(tlb_exc));
        assert (bus_wen === exp_bwen)
            else report_mismatch("bus_wen", 32'(exp_bwen), 32'(bus_wen));
        assert (rdata === exp_rdata)
            else report_mismatch("rdata", exp_rdata, rdata);
        assert (bus_wdata === exp_wdata)
            else report_mismatch("bus_wdata", exp_wdata, bus_wdata);
        if (exp_ben) begin // address only means something when enabled
            assert (bus_paddr === exp_paddr)
                else report_mismatch("bus_paddr", exp_paddr, bus_paddr);
            assert (bus_cached === exp_cached)
                else report_mismatch("bus_cached", 32'(exp_cached), 32'(bus_cached));
        end
    end

    initial begin
        logic [31:0] seed_val;
        logic [19:0] vpn;
        logic [2:0]  k0;
        int          tries;
        seed_val       = $urandom(32'hdbda_6c1d);
        en             = 1'b0;
        wen            = 4'd0;
        vaddr          = 32'd0;
        wdata          = 32'd0;
        exc_flag       = 1'b0;
        bus_rdata      = 32'd0;
        bus_streq      = 1'b0;
        cp0_wen        = 1'b0;
        cp0_sel        = mips_mmu_pkg::cp0_index;
        cp0_wdata      = 32'd0;
        tlb_write      = 1'b0;
        value_errors   = 0;
        timeout_errors = 0;
        m_erl          = 1'b1; // Status comes up with ERL set
        m_k0           = 3'd0;
        m_v            = 8'd0;
        m_d            = 8'd0;
        m_c            = 8'd0;

        tries = 0;
        while (rst_n !== 1'b1 && tries < 20) begin
            @(posedge clk);
            tries++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            timeout_errors++;
        end

        // ERL set: every segment uses the unmapped address
        for (int pass = 0; pass < 2; pass++) begin
            if (pass == 1)
                write_config(3'd3, 3'd3, 3'd3);
            for (int i = 0; i < 4; i++) begin
                run_access(1'b1, 4'd0, {1'b0, 31'($urandom)}, 1'b0);
                run_access(1'b1, 4'd0, {3'b110, 29'($urandom)}, 1'b0);
                run_access(1'b1, 4'd0, {3'b100, 29'($urandom)}, 1'b0);
            end
        end

        // ERL clear, K0 sweep
        cp0_write(mips_mmu_pkg::cp0_status, 32'd0);
        m_erl = 1'b0;
        for (int j = 0; j < 5; j++) begin
            k0 = (j == 0) ? 3'd3 : 3'($urandom);
            write_config(k0, 3'($urandom), 3'($urandom));
            run_access(1'b1, 4'd0, {3'b100, 29'($urandom)}, 1'b0);
            run_access(1'b1, 4'd0, {3'b101, 29'($urandom)}, 1'b0);
        end

        // entry 6 clean, entry 7 invalid
        for (int i = 0; i < 8; i++) begin
            vpn = {pick_mapped_seg(), 14'($urandom), 3'(i)};
            write_entry(i, vpn, 20'($urandom), i != 7, i < 6, 1'($urandom));
        end
        for (int i = 0; i < 7; i++) begin
            run_access(1'b1, 4'd0, {m_vpn[i], 12'($urandom)}, 1'b0);
            run_access(1'b1, (i == 0) ? 4'b1111 : 4'd0, {m_vpn[i], 12'($urandom)}, 1'b0);
            assert (last_wait == 0)
                else begin
                    $display("repeated access to page %h stalled at %0t", m_vpn[i], $time);
                    value_errors++;
                end
        end

        // refill, invalid, modified
        tries = 0;
        do begin
            vpn = {pick_mapped_seg(), 17'($urandom)};
            tries++;
        end while (find_entry(vpn) >= 0 && tries < 100);
        run_access(1'b1, 4'd0, {vpn, 12'($urandom)}, 1'b0);
        run_access(1'b1, 4'd0, {m_vpn[7], 12'($urandom)}, 1'b0);
        run_access(1'b1, 4'b0011, {m_vpn[6], 12'($urandom)}, 1'b0);

        // pipeline exception, idle access, bus back-pressure
        run_access(1'b1, 4'd0, {m_vpn[0], 12'($urandom)}, 1'b1);
        run_access(1'b0, 4'b1010, {m_vpn[1], 12'($urandom)}, 1'b0);
        @(posedge clk);
        bus_streq <= 1'b1;
        @(negedge clk);
        assert (stallreq === 1'b1)
            else report_mismatch("stallreq", 32'd1, 32'(stallreq));
        @(posedge clk);
        bus_streq <= 1'b0;

        // rewritten entry must not come from the stale micro buffer
        run_access(1'b1, 4'd0, {m_vpn[2], 12'($urandom)}, 1'b0);
        run_access(1'b0, 4'd0, 32'd0, 1'b0);
        write_entry(2, m_vpn[2], ~m_pfn[2], 1'b1, 1'b1, m_c[2]);
        run_access(1'b1, 4'd0, {m_vpn[2], 12'($urandom)}, 1'b0);

        @(posedge clk);
        $display("error counts: %0d value mismatches, %0d timeouts", value_errors,
                 timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- build.f
mips_mmu_pkg.sv
cp0_mmu_regs.sv
tlb.sv
mmu.sv
mmu_subsystem.sv
tb_clock_gen.sv
mmu_subsystem_tb.sv

//--- Makefile
# Verilator build of the MMU subsystem testbench; all variables can be overridden

VERILATOR ?= verilator
TOP       ?= mmu_subsystem_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
